// ==== Makefile ====
TOOL     = verilator
TOP      = tb_top
FILELIST = tb.f
FLAGS    = --binary -j 0 -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard testbench/*.svh)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== src/cu_control.sv ====
/*
 * Compute unit control
 * Top of the copy unit: registers all inputs and command outputs,
 * holds the current job, and ties the read engine, data buffer and
 * write engine together. Raises job_done once every line of the
 * job has been read and written back
 */

`default_nettype none

module cu_control (
	input  logic           clock,
	input  logic           rstn,
	input  logic           job_start,
	input  cu_pkg::addr_t  job_src,
	input  cu_pkg::addr_t  job_dst,
	input  cu_pkg::count_t job_lines,
	input  logic           rd_cmd_full,
	input  logic           rd_rsp_valid,
	input  mem_pkg::tag_t  rd_rsp_tag,
	input  mem_pkg::line_t rd_rsp_data,
	input  logic           wr_cmd_full,
	input  logic           wr_rsp_valid,
	output logic           rd_cmd_valid,
	output cu_pkg::addr_t  rd_cmd_addr,
	output mem_pkg::tag_t  rd_cmd_tag,
	output logic           wr_cmd_valid,
	output cu_pkg::addr_t  wr_cmd_addr,
	output mem_pkg::tag_t  wr_cmd_tag,
	output mem_pkg::line_t wr_cmd_data,
	output logic           busy,
	output logic           job_done,
	output cu_pkg::count_t read_count,
	output cu_pkg::count_t write_count
);
	import cu_pkg::*;
	import mem_pkg::*;

	// Latched inputs
	logic   job_start_q;
	addr_t  job_src_q;
	addr_t  job_dst_q;
	count_t job_lines_q;
	logic   rd_cmd_full_q;
	logic   rd_rsp_valid_q;
	tag_t   rd_rsp_tag_q;
	line_t  rd_rsp_data_q;
	logic   wr_cmd_full_q;
	logic   wr_rsp_valid_q;

	// Job state
	count_t lines_q;
	logic   start;
	logic   done_now;

	// Engine and buffer links
	logic       rd_valid_e;
	addr_t      rd_addr_e;
	tag_t       rd_tag_e;
	logic       push;
	tag_t       push_tag;
	line_t      push_data;
	logic       pop;
	tag_t       pop_tag;
	line_t      pop_data;
	logic       empty;
	buf_count_t free_entries;
	logic       wr_valid_e;
	addr_t      wr_addr_e;
	tag_t       wr_tag_e;
	line_t      wr_data_e;
	count_t     rd_done;
	count_t     wr_done;

	////////////////////
	// Input registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			job_start_q    <= 1'b0;
			rd_cmd_full_q  <= 1'b0;
			rd_rsp_valid_q <= 1'b0;
			wr_cmd_full_q  <= 1'b0;
			wr_rsp_valid_q <= 1'b0;
		end else begin
			job_start_q    <= job_start;
			rd_cmd_full_q  <= rd_cmd_full;
			rd_rsp_valid_q <= rd_rsp_valid;
			wr_cmd_full_q  <= wr_cmd_full;
			wr_rsp_valid_q <= wr_rsp_valid;
		end
	end

	always_ff @(posedge clock) begin
		job_src_q     <= job_src;
		job_dst_q     <= job_dst;
		job_lines_q   <= job_lines;
		rd_rsp_tag_q  <= rd_rsp_tag;
		rd_rsp_data_q <= rd_rsp_data;
	end

	////////////////////
	// Job and done
	////////////////////

	// New jobs are dropped while one is running
	assign start    = job_start_q && !busy;
	assign done_now = busy && (rd_done == lines_q) && (wr_done == lines_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			busy <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			else if (done_now)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			lines_q <= job_lines_q;
	end

	////////////////////
	// Engines
	////////////////////

	cu_read_engine read_engine_i (
		.clock       (clock),
		.rstn        (rstn),
		.start       (start),
		.src         (job_src_q),
		.lines       (job_lines_q),
		.cmd_full    (rd_cmd_full_q),
		.free_entries(free_entries),
		.rsp_valid   (rd_rsp_valid_q),
		.rsp_tag     (rd_rsp_tag_q),
		.rsp_data    (rd_rsp_data_q),
		.cmd_valid   (rd_valid_e),
		.cmd_addr    (rd_addr_e),
		.cmd_tag     (rd_tag_e),
		.push        (push),
		.push_tag    (push_tag),
		.push_data   (push_data),
		.done_count  (rd_done)
	);

	cu_data_buffer data_buffer_i (
		.clock       (clock),
		.rstn        (rstn),
		.push        (push),
		.push_tag    (push_tag),
		.push_data   (push_data),
		.pop         (pop),
		.pop_tag     (pop_tag),
		.pop_data    (pop_data),
		.empty       (empty),
		.free_entries(free_entries)
	);

	cu_write_engine write_engine_i (
		.clock     (clock),
		.rstn      (rstn),
		.start     (start),
		.dst       (job_dst_q),
		.empty     (empty),
		.pop_tag   (pop_tag),
		.pop_data  (pop_data),
		.cmd_full  (wr_cmd_full_q),
		.rsp_valid (wr_rsp_valid_q),
		.pop       (pop),
		.cmd_valid (wr_valid_e),
		.cmd_addr  (wr_addr_e),
		.cmd_tag   (wr_tag_e),
		.cmd_data  (wr_data_e),
		.done_count(wr_done)
	);

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rd_cmd_valid <= 1'b0;
			wr_cmd_valid <= 1'b0;
			job_done     <= 1'b0;
			read_count   <= '0;
			write_count  <= '0;
		end else begin
			rd_cmd_valid <= rd_valid_e;
			wr_cmd_valid <= wr_valid_e;
			job_done     <= done_now;
			read_count   <= rd_done;
			write_count  <= wr_done;
		end
	end

	// Command payload
	always_ff @(posedge clock) begin
		rd_cmd_addr <= rd_addr_e;
		rd_cmd_tag  <= rd_tag_e;
		wr_cmd_addr <= wr_addr_e;
		wr_cmd_tag  <= wr_tag_e;
		wr_cmd_data <= wr_data_e;
	end

endmodule

`default_nettype wire

// ==== src/cu_data_buffer.sv ====
/*
 * Line data buffer
 * Small FIFO between the read and write engines holding returned
 * lines with their tags, and reporting how many entries are free
 */

`default_nettype none

module cu_data_buffer (
	input  logic                clock,
	input  logic                rstn,
	input  logic                push,
	input  mem_pkg::tag_t       push_tag,
	input  mem_pkg::line_t      push_data,
	input  logic                pop,
	output mem_pkg::tag_t       pop_tag,
	output mem_pkg::line_t      pop_data,
	output logic                empty,
	output mem_pkg::buf_count_t free_entries
);
	import mem_pkg::*;

	buf_entry_t mem [BUFFER_DEPTH];
	buf_ptr_t   wr_ptr;
	buf_ptr_t   rd_ptr;
	buf_count_t count;
	logic       do_pop;

	assign do_pop = pop && !empty;

	// Storage, no reset on the line data
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= '{tag: push_tag, data: push_data};
	end

	////////////////////
	// Pointers and occupancy
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign pop_tag      = mem[rd_ptr].tag;
	assign pop_data     = mem[rd_ptr].data;
	assign empty        = (count == '0);
	assign free_entries = buf_count_t'(BUFFER_DEPTH) - count;

endmodule

`default_nettype wire

// ==== src/cu_pkg.sv ====
/*
 * Compute unit job package
 * Job-level sizes and types shared by the copy control block:
 * byte addresses, the largest job and the line counters
 */

`default_nettype none

package cu_pkg;

	////////////////////
	// Addresses
	////////////////////

	localparam int unsigned ADDR_BITS = 64;

	// Byte address in shared memory
	typedef logic [ADDR_BITS-1:0] addr_t;

	////////////////////
	// Job length
	////////////////////

	// Largest job in cache lines
	localparam int unsigned MAX_JOB_LINES = 1024;

	// One extra bit so the counter can hold MAX_JOB_LINES itself
	localparam int unsigned COUNT_BITS = $clog2(MAX_JOB_LINES) + 1;

	// Line counter for issue index and completions
	typedef logic [COUNT_BITS-1:0] count_t;

endpackage

`default_nettype wire

// ==== src/cu_read_engine.sv ====
/*
 * Read engine
 * Walks the source array one cache line per command, limited by
 * the free room in the data buffer, and forwards each read response
 * into the buffer while counting completed reads
 */

`default_nettype none

module cu_read_engine (
	input  logic                clock,
	input  logic                rstn,
	input  logic                start,
	input  cu_pkg::addr_t       src,
	input  cu_pkg::count_t      lines,
	input  logic                cmd_full,
	input  mem_pkg::buf_count_t free_entries,
	input  logic                rsp_valid,
	input  mem_pkg::tag_t       rsp_tag,
	input  mem_pkg::line_t      rsp_data,
	output logic                cmd_valid,
	output cu_pkg::addr_t       cmd_addr,
	output mem_pkg::tag_t       cmd_tag,
	output logic                push,
	output mem_pkg::tag_t       push_tag,
	output mem_pkg::line_t      push_data,
	output cu_pkg::count_t      done_count
);
	import cu_pkg::*;
	import mem_pkg::*;

	addr_t      src_q;
	count_t     lines_q;
	count_t     issue_idx;
	buf_count_t in_flight;

	// Job values as seen this cycle, start bypasses the job registers
	addr_t  cur_src;
	count_t cur_lines;
	count_t cur_idx;
	logic   issue;

	always_comb begin
		cur_src   = start ? src : src_q;
		cur_lines = start ? lines : lines_q;
		cur_idx   = start ? '0 : issue_idx;
		// Credit rule keeps every outstanding read a free buffer slot
		issue     = (cur_idx < cur_lines) && !cmd_full && (in_flight < free_entries);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			lines_q    <= '0;
			issue_idx  <= '0;
			in_flight  <= '0;
			cmd_valid  <= 1'b0;
			done_count <= '0;
		end else begin
			if (start)
				lines_q <= lines;
			if (start || issue)
				issue_idx <= cur_idx + count_t'(issue);
			in_flight <= in_flight + buf_count_t'(issue) - buf_count_t'(rsp_valid);
			cmd_valid <= issue;
			if (start)
				done_count <= '0;
			else if (rsp_valid)
				done_count <= done_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			src_q <= src;
		if (issue) begin
			cmd_addr <= cur_src + addr_t'(cur_idx) * LINE_BYTES;
			cmd_tag  <= cur_idx[TAG_BITS-1:0];
		end
	end

	// Responses go straight into the buffer
	assign push      = rsp_valid;
	assign push_tag  = rsp_tag;
	assign push_data = rsp_data;

endmodule

`default_nettype wire

// ==== src/cu_write_engine.sv ====
/*
 * Write engine
 * Drains the data buffer into write commands for the destination
 * array, one line per cycle unless stalled, and counts the
 * completed writes of the current job
 */

`default_nettype none

module cu_write_engine (
	input  logic           clock,
	input  logic           rstn,
	input  logic           start,
	input  cu_pkg::addr_t  dst,
	input  logic           empty,
	input  mem_pkg::tag_t  pop_tag,
	input  mem_pkg::line_t pop_data,
	input  logic           cmd_full,
	input  logic           rsp_valid,
	output logic           pop,
	output logic           cmd_valid,
	output cu_pkg::addr_t  cmd_addr,
	output mem_pkg::tag_t  cmd_tag,
	output mem_pkg::line_t cmd_data,
	output cu_pkg::count_t done_count
);
	import cu_pkg::*;
	import mem_pkg::*;

	addr_t dst_q;
	addr_t line_addr;

	// Take one line whenever the command path has room
	assign pop = !empty && !cmd_full;

	// Destination follows the tag, so reordered reads land in place
	assign line_addr = dst_q + addr_t'(pop_tag) * LINE_BYTES;

	////////////////////
	// Command stage
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			dst_q <= dst;
		if (pop) begin
			cmd_addr <= line_addr;
			cmd_tag  <= pop_tag;
			cmd_data <= pop_data;
		end
	end

	////////////////////
	// Completion count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			done_count <= '0;
		end else begin
			if (start)
				done_count <= '0;
			else if (rsp_valid)
				done_count <= done_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
/*
 * Memory side package
 * Cache line geometry, command tags and the layout
 * of the returned-line buffer between the two engines
 */

`default_nettype none

package mem_pkg;

	////////////////////
	// Cache lines
	////////////////////

	localparam int unsigned LINE_BYTES = 128;
	localparam int unsigned LINE_BITS  = LINE_BYTES * 8;

	// One full line of payload
	typedef logic [LINE_BITS-1:0] line_t;

	////////////////////
	// Command tags
	////////////////////

	// Tag carries the line index within the job
	localparam int unsigned TAG_BITS = 10;

	typedef logic [TAG_BITS-1:0] tag_t;

	////////////////////
	// Data buffer
	////////////////////

	localparam int unsigned BUFFER_DEPTH   = 8;
	localparam int unsigned BUF_PTR_BITS   = $clog2(BUFFER_DEPTH);
	localparam int unsigned BUF_COUNT_BITS = BUF_PTR_BITS + 1;

	typedef logic [BUF_PTR_BITS-1:0]   buf_ptr_t;
	typedef logic [BUF_COUNT_BITS-1:0] buf_count_t;

	// Returned read line with its tag
	typedef struct packed {
		tag_t  tag;
		line_t data;
	} buf_entry_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
src/cu_pkg.sv
src/mem_pkg.sv
src/cu_read_engine.sv
src/cu_data_buffer.sv
src/cu_write_engine.sv
src/cu_control.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== testbench/line_pattern.svh ====
/*
 * Memory line pattern
 * Contents of a source line as a function of its byte address,
 * shared by the memory model and the checker
 */

function automatic mem_pkg::line_t line_pattern(input cu_pkg::addr_t addr);
	mem_pkg::line_t pattern;
	logic [63:0]    word;
	for (int w = 0; w < mem_pkg::LINE_BITS / 64; w++) begin
		// Every word mixes the full address with its position
		word = {addr[31:0], addr[63:32]} + 64'(w) * 64'h9e37_79b9_7f4a_7c15;
		pattern[w*64 +: 64] = word ^ addr;
	end
	return pattern;
endfunction

// ==== testbench/tb_checker.sv ====
/*
 * Copy unit checker
 * Watches commands and status of the control block, checks them
 * against the current job and prints one line per finished job
 */

`default_nettype none

module tb_checker (
	input  logic           clock,
	input  logic           rstn,
	input  logic           job_begin,
	input  logic           job_end,
	input  logic           report,
	input  cu_pkg::addr_t  exp_src,
	input  cu_pkg::addr_t  exp_dst,
	input  cu_pkg::count_t exp_lines,
	input  logic           rd_cmd_full,
	input  logic           wr_cmd_full,
	input  logic           rd_cmd_valid,
	input  cu_pkg::addr_t  rd_cmd_addr,
	input  mem_pkg::tag_t  rd_cmd_tag,
	input  logic           wr_cmd_valid,
	input  cu_pkg::addr_t  wr_cmd_addr,
	input  mem_pkg::tag_t  wr_cmd_tag,
	input  mem_pkg::line_t wr_cmd_data,
	input  logic           busy,
	input  logic           job_done,
	input  cu_pkg::count_t read_count,
	input  cu_pkg::count_t write_count,
	output int             errors
);
	import cu_pkg::*;
	import mem_pkg::*;

	`include "line_pattern.svh"

	logic       rd_seen [MAX_JOB_LINES];
	logic       wr_seen [MAX_JOB_LINES];
	// Full inputs of the last three cycles, oldest in bit 2
	logic [2:0] rd_full_hist;
	logic [2:0] wr_full_hist;
	logic       counting;
	logic       reset_checked;
	int         checks;
	int         jobs;
	int         errors_base;
	int         done_pulses;
	int         rd_total;
	int         wr_total;

	task automatic compare(input string name, input line_t expected, input line_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %0h, got %0h", name, expected, actual);
		end
	endtask

	task automatic problem(input string what);
		errors++;
		$display("%s", what);
	endtask

	function automatic addr_t line_addr(input addr_t base, input tag_t tag);
		return base + addr_t'(tag) * addr_t'(LINE_BYTES);
	endfunction

	always @(posedge clock) begin : watch
		int i;
		if (!rstn) begin
			errors        = 0;
			checks        = 0;
			jobs          = 0;
			rd_full_hist  = '0;
			wr_full_hist  = '0;
			counting      = 1'b0;
			reset_checked = 1'b0;
		end else begin
			////////////////////
			// State right after reset
			////////////////////
			if (!reset_checked) begin
				compare("rd_cmd_valid", '0, line_t'(rd_cmd_valid));
				compare("wr_cmd_valid", '0, line_t'(wr_cmd_valid));
				compare("busy", '0, line_t'(busy));
				compare("job_done", '0, line_t'(job_done));
				compare("read_count", '0, line_t'(read_count));
				compare("write_count", '0, line_t'(write_count));
				$display("reset state: %s", (errors == 0) ? "ok" : "FAILED");
				reset_checked = 1'b1;
			end

			if (job_begin) begin
				for (i = 0; i < MAX_JOB_LINES; i++) begin
					rd_seen[i] = 1'b0;
					wr_seen[i] = 1'b0;
				end
				rd_total    = 0;
				wr_total    = 0;
				done_pulses = 0;
				counting    = 1'b0;
				errors_base = errors;
			end else if (!counting && read_count == '0 && write_count == '0) begin
				// Old job's counts are gone once both read zero
				counting = 1'b1;
			end

			////////////////////
			// Commands
			////////////////////
			if (rd_cmd_valid) begin
				if (rd_full_hist[2])
					problem("read command issued while rd_cmd_full was high");
				if (count_t'(rd_cmd_tag) >= exp_lines)
					problem($sformatf("read tag %0d is outside the job", rd_cmd_tag));
				else if (rd_seen[rd_cmd_tag])
					problem($sformatf("read tag %0d issued twice", rd_cmd_tag));
				else begin
					rd_seen[rd_cmd_tag] = 1'b1;
					rd_total++;
				end
				compare("rd_cmd_addr", line_t'(line_addr(exp_src, rd_cmd_tag)),
					line_t'(rd_cmd_addr));
			end

			if (wr_cmd_valid) begin
				if (wr_full_hist[2])
					problem("write command issued while wr_cmd_full was high");
				if (count_t'(wr_cmd_tag) >= exp_lines)
					problem($sformatf("write tag %0d is outside the job", wr_cmd_tag));
				else if (wr_seen[wr_cmd_tag])
					problem($sformatf("write tag %0d issued twice", wr_cmd_tag));
				else begin
					if (!rd_seen[wr_cmd_tag])
						problem($sformatf("write tag %0d came before its read", wr_cmd_tag));
					wr_seen[wr_cmd_tag] = 1'b1;
					wr_total++;
				end
				compare("wr_cmd_addr", line_t'(line_addr(exp_dst, wr_cmd_tag)),
					line_t'(wr_cmd_addr));
				compare("wr_cmd_data", line_pattern(line_addr(exp_src, wr_cmd_tag)), wr_cmd_data);
			end

			////////////////////
			// Counts and done
			////////////////////
			checks++;
			if (read_count < write_count) begin
				errors++;
				$display("error write_count: %0h above read_count %0h", write_count, read_count);
			end
			if (counting && (read_count > exp_lines || write_count > exp_lines)) begin
				errors++;
				$display("error read_count: %0h, write_count: %0h, job length %0h",
					read_count, write_count, exp_lines);
			end

			if (job_done) begin
				done_pulses++;
				compare("read_count", line_t'(exp_lines), line_t'(read_count));
				compare("write_count", line_t'(exp_lines), line_t'(write_count));
				compare("busy", '0, line_t'(busy));
			end

			if (job_end) begin
				jobs++;
				if (rd_total != int'(exp_lines))
					problem($sformatf("only %0d of %0d lines were read", rd_total, exp_lines));
				if (wr_total != int'(exp_lines))
					problem($sformatf("only %0d of %0d lines were written", wr_total, exp_lines));
				if (done_pulses != 1)
					problem($sformatf("job_done pulsed %0d times", done_pulses));
				$display("job %0d: %0d lines, %s", jobs, exp_lines,
					(errors == errors_base) ? "ok" : "FAILED");
			end

			if (report)
				$display("jobs %0d, checks %0d, errors %0d", jobs, checks, errors);

			rd_full_hist = {rd_full_hist[1:0], rd_cmd_full};
			wr_full_hist = {wr_full_hist[1:0], wr_cmd_full};
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
/*
 * Copy unit testbench
 * Applies a table of jobs to the control block and models the
 * memory side with random delays, reordered read responses and
 * random full stalls on both command paths
 */

`default_nettype none

module tb_top;
	import cu_pkg::*;
	import mem_pkg::*;

	`include "line_pattern.svh"

	localparam int NUM_JOBS   = 5;
	localparam int WAIT_LIMIT = 50000;

	logic  clock        = 1'b0;
	logic  rstn;
	logic  job_start;
	addr_t job_src;
	addr_t job_dst;
	count_t job_lines;
	logic  rd_cmd_full  = 1'b0;
	logic  rd_rsp_valid = 1'b0;
	tag_t  rd_rsp_tag   = '0;
	line_t rd_rsp_data  = '0;
	logic  wr_cmd_full  = 1'b0;
	logic  wr_rsp_valid = 1'b0;
	logic  rd_cmd_valid;
	addr_t rd_cmd_addr;
	tag_t  rd_cmd_tag;
	logic  wr_cmd_valid;
	addr_t wr_cmd_addr;
	tag_t  wr_cmd_tag;
	line_t wr_cmd_data;
	logic  busy;
	logic  job_done;
	count_t read_count;
	count_t write_count;

	// Checker side
	logic   job_begin;
	logic   job_end;
	logic   report;
	addr_t  exp_src;
	addr_t  exp_dst;
	count_t exp_lines;
	int     errors;

	// Job table: source, destination, lines, stall percent, second start while busy
	addr_t tbl_src [NUM_JOBS] = '{64'h0000_0000_0010_0000, 64'h0000_0004_0000_0000,
		64'h0000_0000_0000_0080, 64'h0000_0010_0000_0000, 64'h0000_0000_0040_0000};
	addr_t tbl_dst [NUM_JOBS] = '{64'h0000_0000_0080_0000, 64'h0000_0008_0000_1000,
		64'h0000_0000_0000_0f00, 64'h0000_0020_0000_0000, 64'h0000_0000_00c0_0000};
	int tbl_lines    [NUM_JOBS] = '{16, 16, 1, 1024, 16};
	int tbl_rd_stall [NUM_JOBS] = '{0, 30, 10, 20, 10};
	int tbl_wr_stall [NUM_JOBS] = '{0, 30, 10, 20, 10};
	bit tbl_intrude  [NUM_JOBS] = '{0, 0, 0, 0, 1};

	logic [31:0] rng = 32'd6;
	int          rd_stall_pct;
	int          wr_stall_pct;
	addr_t       rd_addr_q [$];
	tag_t        rd_tag_q  [$];
	int          rd_wait_q [$];
	int          wr_wait_q [$];

	always #2 clock = ~clock;

	cu_control dut_i (
		.clock(clock), .rstn(rstn), .job_start(job_start), .job_src(job_src),
		.job_dst(job_dst), .job_lines(job_lines), .rd_cmd_full(rd_cmd_full),
		.rd_rsp_valid(rd_rsp_valid), .rd_rsp_tag(rd_rsp_tag), .rd_rsp_data(rd_rsp_data),
		.wr_cmd_full(wr_cmd_full), .wr_rsp_valid(wr_rsp_valid),
		.rd_cmd_valid(rd_cmd_valid), .rd_cmd_addr(rd_cmd_addr), .rd_cmd_tag(rd_cmd_tag),
		.wr_cmd_valid(wr_cmd_valid), .wr_cmd_addr(wr_cmd_addr), .wr_cmd_tag(wr_cmd_tag),
		.wr_cmd_data(wr_cmd_data), .busy(busy), .job_done(job_done),
		.read_count(read_count), .write_count(write_count)
	);

	tb_checker checker_i (
		.clock(clock), .rstn(rstn), .job_begin(job_begin), .job_end(job_end),
		.report(report), .exp_src(exp_src), .exp_dst(exp_dst), .exp_lines(exp_lines),
		.rd_cmd_full(rd_cmd_full), .wr_cmd_full(wr_cmd_full),
		.rd_cmd_valid(rd_cmd_valid), .rd_cmd_addr(rd_cmd_addr), .rd_cmd_tag(rd_cmd_tag),
		.wr_cmd_valid(wr_cmd_valid), .wr_cmd_addr(wr_cmd_addr), .wr_cmd_tag(wr_cmd_tag),
		.wr_cmd_data(wr_cmd_data), .busy(busy), .job_done(job_done),
		.read_count(read_count), .write_count(write_count), .errors(errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	////////////////////
	// Memory model
	////////////////////

	always @(negedge clock) begin : memory_model
		int n;
		int first;
		int sel;
		if (rstn) begin
			rd_cmd_full = (next_random() % 100) < rd_stall_pct;
			wr_cmd_full = (next_random() % 100) < wr_stall_pct;
			foreach (rd_wait_q[i])
				if (rd_wait_q[i] > 0)
					rd_wait_q[i] = rd_wait_q[i] - 1;
			foreach (wr_wait_q[i])
				if (wr_wait_q[i] > 0)
					wr_wait_q[i] = wr_wait_q[i] - 1;
			if (rd_cmd_valid) begin
				rd_addr_q.push_back(rd_cmd_addr);
				rd_tag_q.push_back(rd_cmd_tag);
				rd_wait_q.push_back(1 + int'(next_random() % 6));
			end
			if (wr_cmd_valid)
				wr_wait_q.push_back(1 + int'(next_random() % 6));

			// Ready reads answered from a random starting point, so order varies
			n     = rd_wait_q.size();
			sel   = -1;
			first = (n > 0) ? int'(next_random() % n) : 0;
			for (int k = 0; k < n; k++)
				if (sel < 0 && rd_wait_q[(first + k) % n] == 0)
					sel = (first + k) % n;
			rd_rsp_valid = (sel >= 0);
			if (sel >= 0) begin
				rd_rsp_tag  = rd_tag_q[sel];
				rd_rsp_data = line_pattern(rd_addr_q[sel]);
				rd_addr_q.delete(sel);
				rd_tag_q.delete(sel);
				rd_wait_q.delete(sel);
			end

			sel = -1;
			for (int k = 0; k < wr_wait_q.size(); k++)
				if (sel < 0 && wr_wait_q[k] == 0)
					sel = k;
			wr_rsp_valid = (sel >= 0);
			if (sel >= 0)
				wr_wait_q.delete(sel);
		end
	end

	////////////////////
	// Waits and jobs
	////////////////////

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("Verification failed");
		$finish;
	endtask

	task automatic wait_busy();
		int cycles;
		cycles = 0;
		while (!busy) begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_timeout("busy never went high after job_start");
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!job_done) begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_timeout("job_done never arrived");
		end
	endtask

	// At least one cycle, so a second done pulse still counts for this job
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_timeout("memory model still had responses pending");
		end while (busy || rd_wait_q.size() != 0 || wr_wait_q.size() != 0);
	endtask

	task automatic run_job(input int row);
		rd_stall_pct = tbl_rd_stall[row];
		wr_stall_pct = tbl_wr_stall[row];
		exp_src      = tbl_src[row];
		exp_dst      = tbl_dst[row];
		exp_lines    = count_t'(tbl_lines[row]);
		job_src      = tbl_src[row];
		job_dst      = tbl_dst[row];
		job_lines    = count_t'(tbl_lines[row]);
		job_start    = 1'b1;
		job_begin    = 1'b1;
		@(negedge clock);
		job_start = 1'b0;
		job_begin = 1'b0;
		if (tbl_intrude[row]) begin
			wait_busy();
			job_src   = 64'h7000_0000_0000_0000;
			job_dst   = 64'h7800_0000_0000_0000;
			job_lines = count_t'(4);
			job_start = 1'b1;
			@(negedge clock);
			job_start = 1'b0;
		end
		wait_done();
		wait_idle();
		job_end = 1'b1;
		@(negedge clock);
		job_end = 1'b0;
	endtask

	initial begin
		rstn         = 1'b0;
		job_start    = 1'b0;
		job_src      = '0;
		job_dst      = '0;
		job_lines    = '0;
		job_begin    = 1'b0;
		job_end      = 1'b0;
		report       = 1'b0;
		exp_src      = '0;
		exp_dst      = '0;
		exp_lines    = '0;
		rd_stall_pct = 0;
		wr_stall_pct = 0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		for (int row = 0; row < NUM_JOBS; row++)
			run_job(row);
		report = 1'b1;
		@(negedge clock);
		report = 1'b0;
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
